// ==== logic/fmaPostPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// fma post-normalization shared definitions
// format and rounding enums, pipeline structs and format constants
// for the single (main) and half (narrow) result formats
////////////////////////////////////////////////////////////////////////////

package fmaPostPkg;

  // main format is single precision
  localparam int NE = 8;
  localparam int NF = 23;
  // narrow format is half precision
  localparam int NE1 = 5;
  localparam int NF1 = 10;

  localparam int BIAS = 127;
  localparam int BIAS1 = 15;

  // raw fma sum magnitude width and normalization shift count width
  localparam int SumWidth = 3 * NF + 4;
  localparam int ShiftWidth = 7;

  // 1 selects the larger format
  typedef enum logic {
    fmtHalf = 1'b0,
    fmtSingle = 1'b1
  } fmtE;

  typedef enum logic {
    rmRne = 1'b0,
    rmRtz = 1'b1
  } rmE;

  // sum from the fma datapath, exponent biased for single
  typedef struct packed {
    logic sign;
    logic [NE+1:0] sumExp;
    logic [SumWidth-1:0] sumMant;
  } sumT;

  // shift calculation results handed to the normalization shifter
  typedef struct packed {
    logic [NE+1:0] normExp;
    logic preSubnorm;
    logic sumZero;
    logic [ShiftWidth-1:0] shiftAmt;
    logic [SumWidth+1:0] shiftIn;
  } shiftT;

  // normalized significand with rounding bits
  typedef struct packed {
    logic sign;
    logic [NE+1:0] exp;
    logic [NF:0] mant;
    logic guard;
    logic sticky;
    logic zero;
    logic subnorm;
  } normT;

  typedef struct packed {
    logic [31:0] bits;
    logic zero;
    logic subnorm;
    logic inexact;
  } resultT;

endpackage

// ==== logic/fmaModeRegs.sv ====
////////////////////////////////////////////////////////////////////////////
// fma post-normalization mode registers
// holds the result format and rounding mode that steer the pipeline
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fmaModeRegs (
  input  logic clk,
  input  logic rst,
  // configuration write strobe and data
  input  logic cfgWe,
  input  fmaPostPkg::fmtE cfgFmt,
  input  fmaPostPkg::rmE cfgRm,
  // live mode seen by the pipeline
  output fmaPostPkg::fmtE fmt,
  output fmaPostPkg::rmE rm
);

  fmaPostPkg::fmtE fmtQ;
  fmaPostPkg::rmE rmQ;

  // single precision with nearest-even out of reset
  // a write takes effect for operations issued in the next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      fmtQ <= fmaPostPkg::fmtSingle;
      rmQ <= fmaPostPkg::rmRne;
    end else if (cfgWe) begin
      fmtQ <= cfgFmt;
      rmQ <= cfgRm;
    end
  end

  // in-flight operations carry their own copy further down
  // so a write here never disturbs them
  assign fmt = fmtQ;
  assign rm = rmQ;

endmodule

// ==== logic/sumLzc.sv ====
////////////////////////////////////////////////////////////////////////////
// sum leading zero counter
// exact count of leading zeros in the fma sum magnitude
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sumLzc (
  input  logic [fmaPostPkg::SumWidth-1:0] sumMant,
  output logic [fmaPostPkg::ShiftWidth-1:0] sCnt
);

  localparam int Width = fmaPostPkg::SumWidth;
  localparam int CntW = fmaPostPkg::ShiftWidth;

  // count must be able to hold the full width for a zero sum
  logic [CntW-1:0] cnt;

  ////////////////////////////////////////////////////////////////////////////
  // priority scan
  ////////////////////////////////////////////////////////////////////////////

  // scan from the lsb up so the highest set bit is the last hit
  // and decides the count
  always_comb begin
    cnt = CntW'(Width);
    for (int i = 0; i < Width; i++) begin
      if (sumMant[i]) begin
        cnt = CntW'(Width - 1 - i);
      end
    end
  end

  // an all-zero sum yields Width
  // the shift calc zero flag overrides everything downstream
  assign sCnt = cnt;

endmodule

// ==== logic/fmaShiftCalc.sv ====
////////////////////////////////////////////////////////////////////////////
// fma shift calculation
// normalized exponent with bias correction for the narrow format,
// zero and subnormal prediction, and the normalization shift amount
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fmaShiftCalc #(
  parameter int Ne = fmaPostPkg::NE,
  parameter int Nf = fmaPostPkg::NF
) (
  input  fmaPostPkg::fmtE fmt,
  input  fmaPostPkg::sumT sum,
  input  logic [fmaPostPkg::ShiftWidth-1:0] sCnt,
  output fmaPostPkg::shiftT shift
);

  localparam int ExpW = Ne + 2;
  localparam int CntW = fmaPostPkg::ShiftWidth;
  // main format bias derived from the exponent width
  localparam int Bias = (1 << (Ne - 1)) - 1;

  logic [ExpW-1:0] preNormExp;
  logic [ExpW-1:0] biasCorr;
  logic [ExpW-1:0] normExp;
  logic sumZero;
  logic expLez;
  logic expGeFl;
  logic preSubnorm;
  logic [CntW-1:0] subnormAmt;

  ////////////////////////////////////////////////////////////////////////////
  // exponent
  ////////////////////////////////////////////////////////////////////////////

  // leading one at bit (SumWidth-1-sCnt) of the sum
  // value is sumMant * 2^(sumExp - bias - 2nf - 2)
  // so the biased exponent of 1.xxx is sumExp - sCnt + nf + 1
  assign preNormExp = sum.sumExp - ExpW'(sCnt) + ExpW'(Nf + 1);

  // re-bias into half when the narrow format is active
  assign biasCorr = (fmt == fmaPostPkg::fmtSingle) ? '0 :
                    ExpW'(fmaPostPkg::BIAS1 - Bias);
  assign normExp = preNormExp + biasCorr;

  assign sumZero = ~|sum.sumMant;

  ////////////////////////////////////////////////////////////////////////////
  // subnormal prediction
  ////////////////////////////////////////////////////////////////////////////

  // subnormal when the normalized exponent is at or below zero
  assign expLez = $signed(normExp) <= 0;

  // lower bound keeps the result within reach of the smallest subnormal
  always_comb begin
    if (fmt == fmaPostPkg::fmtSingle) begin
      expGeFl = $signed(normExp) >= -(Nf + 2);
    end else begin
      expGeFl = $signed(normExp) >= -(fmaPostPkg::NF1 + 2);
    end
  end

  assign preSubnorm = expLez & expGeFl & ~sumZero;

  ////////////////////////////////////////////////////////////////////////////
  // shift amount
  ////////////////////////////////////////////////////////////////////////////

  // exponent limited shift for subnormals
  // this lands one bit past the normal window and the shifter compensates
  // modulo arithmetic is enough since the true amount fits the count width
  assign subnormAmt = sum.sumExp[CntW-1:0] + CntW'(Nf + 2) + biasCorr[CntW-1:0];

  assign shift.normExp = normExp;
  assign shift.preSubnorm = preSubnorm;
  assign shift.sumZero = sumZero;
  // normal case puts the leading one just below the top guard zero
  assign shift.shiftAmt = preSubnorm ? subnormAmt : sCnt + CntW'(1);
  assign shift.shiftIn = {2'b00, sum.sumMant};

endmodule

// ==== logic/normShifter.sv ====
////////////////////////////////////////////////////////////////////////////
// normalization shifter
// left shift of the sum, mantissa and guard extraction for the format,
// sticky reduction, and the first pipeline register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module normShifter #(
  parameter int Ne = fmaPostPkg::NE,
  parameter int Nf = fmaPostPkg::NF
) (
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  input  logic sign,
  input  fmaPostPkg::fmtE fmt,
  input  fmaPostPkg::rmE rm,
  input  fmaPostPkg::shiftT shift,
  output fmaPostPkg::normT norm,
  output logic normValid,
  output fmaPostPkg::fmtE normFmt,
  output fmaPostPkg::rmE normRm
);

  localparam int ShW = 3 * Nf + 6;
  // top of the aligned window, one bit wider than the shifter
  localparam int Top = ShW - 1;
  localparam int Nf1 = fmaPostPkg::NF1;

  logic [ShW-1:0] shiftOut;
  logic [ShW:0] aligned;
  logic [Nf:0] mantSel;
  logic guardSel;
  logic stickySel;
  logic [Ne+1:0] expSel;

  assign shiftOut = shift.shiftIn << shift.shiftAmt;

  // normal sums put the leading one at Top-1
  // subnormal shifts overshoot by one so their window sits one bit lower
  assign aligned = shift.preSubnorm ? {1'b0, shiftOut} : {shiftOut, 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // window per format
  ////////////////////////////////////////////////////////////////////////////

  // half mantissa occupies the low bits so the packer sees the lsb at bit 0
  always_comb begin
    if (fmt == fmaPostPkg::fmtSingle) begin
      mantSel = aligned[Top -: Nf + 1];
      guardSel = aligned[Top - Nf - 1];
      stickySel = |aligned[Top - Nf - 2:0];
    end else begin
      mantSel = (Nf + 1)'(aligned[Top -: Nf1 + 1]);
      guardSel = aligned[Top - Nf1 - 1];
      stickySel = |aligned[Top - Nf1 - 2:0];
    end
  end

  // exponent field is zero for subnormal and zero results
  assign expSel = (shift.preSubnorm | shift.sumZero) ? '0 : shift.normExp[Ne+1:0];

  ////////////////////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      normValid <= 1'b0;
    end else begin
      normValid <= inValid;
    end
  end

  // payload and captured mode follow the operation
  always_ff @(posedge clk) begin
    if (inValid) begin
      norm.sign <= sign;
      norm.exp <= expSel;
      norm.mant <= mantSel;
      norm.guard <= guardSel;
      norm.sticky <= stickySel;
      norm.zero <= shift.sumZero;
      norm.subnorm <= shift.preSubnorm;
      normFmt <= fmt;
      normRm <= rm;
    end
  end

endmodule

// ==== logic/resultPacker.sv ====
////////////////////////////////////////////////////////////////////////////
// result rounder and packer
// nearest-even or toward-zero rounding, exponent carry and packing
// into single or half, registered with the result flags
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module resultPacker #(
  parameter int Ne = fmaPostPkg::NE,
  parameter int Nf = fmaPostPkg::NF
) (
  input  logic clk,
  input  logic rst,
  input  logic normValid,
  input  fmaPostPkg::fmtE normFmt,
  input  fmaPostPkg::rmE normRm,
  input  fmaPostPkg::normT norm,
  output fmaPostPkg::resultT result,
  output logic outValid
);

  localparam int Ne1 = fmaPostPkg::NE1;
  localparam int Nf1 = fmaPostPkg::NF1;

  logic roundUp;
  logic [Ne+Nf-1:0] packS;
  logic [Ne1+Nf1-1:0] packH;
  logic expZero;
  fmaPostPkg::resultT resNext;

  ////////////////////////////////////////////////////////////////////////////
  // rounding decision
  ////////////////////////////////////////////////////////////////////////////

  // ties go to the even mantissa
  // toward zero just truncates
  assign roundUp = (normRm == fmaPostPkg::rmRne) & norm.guard &
                   (norm.sticky | norm.mant[0]);

  // adding into {exp, frac} lets a fraction overflow carry into the exponent
  // a subnormal with all fraction bits set becomes the smallest normal
  assign packS = {norm.exp[Ne-1:0], norm.mant[Nf-1:0]} + (Ne + Nf)'(roundUp);
  assign packH = {norm.exp[Ne1-1:0], norm.mant[Nf1-1:0]} + (Ne1 + Nf1)'(roundUp);

  ////////////////////////////////////////////////////////////////////////////
  // assembly
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (normFmt == fmaPostPkg::fmtSingle) begin
      resNext.bits = {norm.sign, packS};
      expZero = ~|packS[Ne+Nf-1:Nf];
    end else begin
      // half result in the low half and upper bits clear
      resNext.bits = {16'h0000, norm.sign, packH};
      expZero = ~|packH[Ne1+Nf1-1:Nf1];
    end
  end

  // only a predicted subnormal can end with a zero exponent field
  // unless rounding carried it up to the smallest normal
  assign resNext.zero = norm.zero;
  assign resNext.subnorm = norm.subnorm & expZero;
  assign resNext.inexact = norm.guard | norm.sticky;

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
      outValid <= 1'b0;
    end else begin
      outValid <= normValid;
      // result holds between operations
      if (normValid) begin
        result <= resNext;
      end
    end
  end

endmodule

// ==== logic/fmaPostTop.sv ====
////////////////////////////////////////////////////////////////////////////
// fma post-normalization top level
// mode registers followed by the two stage normalize and round pipeline
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fmaPostTop #(
  parameter int Ne = fmaPostPkg::NE,
  parameter int Nf = fmaPostPkg::NF
) (
  input  logic clk,
  input  logic rst,
  input  logic cfgWe,
  input  fmaPostPkg::fmtE cfgFmt,
  input  fmaPostPkg::rmE cfgRm,
  input  logic inValid,
  input  fmaPostPkg::sumT sum,
  output fmaPostPkg::resultT result,
  output logic outValid
);

  fmaPostPkg::fmtE fmt;
  fmaPostPkg::rmE rm;
  logic [fmaPostPkg::ShiftWidth-1:0] sCnt;
  fmaPostPkg::shiftT shift;
  fmaPostPkg::normT norm;
  logic normValid;
  fmaPostPkg::fmtE normFmt;
  fmaPostPkg::rmE normRm;

  fmaModeRegs i_modeRegs (
    .clk(clk),
    .rst(rst),
    .cfgWe(cfgWe),
    .cfgFmt(cfgFmt),
    .cfgRm(cfgRm),
    .fmt(fmt),
    .rm(rm)
  );

  // combinational front end ahead of the first register
  sumLzc i_lzc (
    .sumMant(sum.sumMant),
    .sCnt(sCnt)
  );

  fmaShiftCalc #(.Ne(Ne), .Nf(Nf)) i_shiftCalc (
    .fmt(fmt),
    .sum(sum),
    .sCnt(sCnt),
    .shift(shift)
  );

  // stage 1 captures the mode with the operation
  normShifter #(.Ne(Ne), .Nf(Nf)) i_shifter (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .sign(sum.sign),
    .fmt(fmt),
    .rm(rm),
    .shift(shift),
    .norm(norm),
    .normValid(normValid),
    .normFmt(normFmt),
    .normRm(normRm)
  );

  // stage 2 rounds and packs
  resultPacker #(.Ne(Ne), .Nf(Nf)) i_packer (
    .clk(clk),
    .rst(rst),
    .normValid(normValid),
    .normFmt(normFmt),
    .normRm(normRm),
    .norm(norm),
    .result(result),
    .outValid(outValid)
  );

endmodule

// ==== test/fmaPostChk.sv ====
////////////////////////////////////////////////////////////////////////////
// fma post-normalization timing checker
// concurrent assertions on the pipeline latency, reset and result flags
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fmaPostChk (
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  input  logic outValid,
  input  fmaPostPkg::resultT result
);

  // an operation sampled at edge N shows up as outValid sampled at edge N+2
  // both pipeline edges must lie outside reset
  validLatency: assert property (@(posedge clk) disable iff (rst)
    (!$past(rst, 1) && !$past(rst, 2)) |-> (outValid == $past(inValid, 2)))
    else $error("outValid does not follow inValid by exactly two cycles");

  // after the first reset edge the output stage stays cleared
  quietInReset: assert property (@(posedge clk)
    (rst && $past(rst)) |-> !outValid)
    else $error("outValid is high while reset is held");

  // a zero sum is never reported as a subnormal
  flagsExclusive: assert property (@(posedge clk) disable iff (rst)
    !(result.zero && result.subnorm))
    else $error("zero and subnorm flags are both set");

endmodule

// ==== test/fmaPostTb.sv ====
////////////////////////////////////////////////////////////////////////////
// fma post-normalization testbench
// streams the operations of the patterns file through the DUT,
// changing mode between groups, and checks every packed result
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fmaPostTb;

  localparam int MaxPat = 32;
  localparam int Fields = 10;
  localparam logic [15:0] FillTag = 16'hA5C3;
  localparam time DriveSkew = 1ns;
  // issue to outValid in clock cycles
  localparam int Latency = 2;

  logic clk;
  logic rst;
  logic cfgWe;
  fmaPostPkg::fmtE cfgFmt;
  fmaPostPkg::rmE cfgRm;
  logic inValid;
  fmaPostPkg::sumT sum;
  fmaPostPkg::resultT result;
  logic outValid;

  // one word per hex field, ten fields per operation
  logic [79:0] patMem [0:MaxPat*Fields-1];
  fmaPostPkg::resultT expQ[$];
  string nameQ[$];
  int patCount;
  int issued;
  int pulses;
  int cycles;
  int cycleLimit;

  fmaPostTop #(.Ne(fmaPostPkg::NE), .Nf(fmaPostPkg::NF)) i_dut (
    .clk(clk),
    .rst(rst),
    .cfgWe(cfgWe),
    .cfgFmt(cfgFmt),
    .cfgRm(cfgRm),
    .inValid(inValid),
    .sum(sum),
    .result(result),
    .outValid(outValid)
  );

  bind fmaPostTop fmaPostChk i_chk (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .outValid(outValid),
    .result(result)
  );

  // 40 ns period
  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  function automatic string resultText(input fmaPostPkg::resultT r);
    return $sformatf("bits %h zero %b subnorm %b inexact %b",
                     r.bits, r.zero, r.subnorm, r.inexact);
  endfunction

  task automatic checkResult(input string name, input fmaPostPkg::resultT expected,
                             input fmaPostPkg::resultT actual);
    if (actual !== expected) begin
      abortRun($sformatf("error %s: expected %s, actual %s", name,
                         resultText(expected), resultText(actual)));
    end
  endtask

  task automatic checkCount(input string name, input int expected, input int actual);
    if (actual != expected) begin
      abortRun($sformatf("error %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  // unread words keep an address dependent tag so the pattern count can be found
  task automatic loadPatterns();
    for (int a = 0; a < MaxPat * Fields; a++) begin
      patMem[a] = {FillTag, 64'(a)};
    end
    $readmemh("test/fmaPostPatterns.txt", patMem);
    patCount = 0;
    while (patCount < MaxPat && patMem[patCount * Fields][79:64] != FillTag) begin
      patCount++;
    end
    if (patCount == 0) begin
      abortRun("no operations could be read from the patterns file");
    end
  endtask

  function automatic bit modeDiffers(input int n, input int m);
    return patMem[n * Fields + 1][0] != patMem[m * Fields + 1][0] ||
           patMem[n * Fields + 2][0] != patMem[m * Fields + 2][0];
  endfunction

  task automatic writeConfigFor(input int n);
    cfgWe = 1'b1;
    cfgFmt = fmaPostPkg::fmtE'(patMem[n * Fields + 1][0]);
    cfgRm = fmaPostPkg::rmE'(patMem[n * Fields + 2][0]);
  endtask

  // drives one operation and queues its expected result
  task automatic driveOp(input int n);
    int b;
    fmaPostPkg::resultT expected;
    b = n * Fields;
    sum.sign = patMem[b + 3][0];
    sum.sumExp = patMem[b + 4][fmaPostPkg::NE+1:0];
    sum.sumMant = patMem[b + 5][fmaPostPkg::SumWidth-1:0];
    inValid = 1'b1;
    expected.bits = patMem[b + 6][31:0];
    expected.zero = patMem[b + 7][0];
    expected.subnorm = patMem[b + 8][0];
    expected.inexact = patMem[b + 9][0];
    expQ.push_back(expected);
    nameQ.push_back($sformatf("pattern 0x%02h", patMem[b][7:0]));
    issued++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor and timeout
  ////////////////////////////////////////////////////////////////////////////

  // outputs settle after the rising edge, look at them half a cycle later
  always @(negedge clk) begin
    if (!rst && outValid) begin
      pulses++;
      if (expQ.size() == 0) begin
        abortRun("output valid pulse arrived with no operation outstanding");
      end else begin
        checkResult(nameQ.pop_front(), expQ.pop_front(), result);
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycleLimit > 0 && cycles > cycleLimit) begin
      abortRun($sformatf("timeout, the run did not finish within %0d cycles", cycleLimit));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    cfgWe = 1'b0;
    cfgFmt = fmaPostPkg::fmtSingle;
    cfgRm = fmaPostPkg::rmRne;
    inValid = 1'b0;
    sum = '0;
    issued = 0;
    pulses = 0;
    cycles = 0;
    cycleLimit = 0;
    loadPatterns();
    // generous bound covering reset, one issue cycle per operation and drain
    cycleLimit = (patCount + 20) * 4;
    repeat (4) @(posedge clk);
    #(DriveSkew);
    rst = 1'b0;
    // first group mode goes in one cycle ahead of its first operation
    @(posedge clk);
    #(DriveSkew);
    writeConfigFor(0);
    for (int n = 0; n < patCount; n++) begin
      @(posedge clk);
      #(DriveSkew);
      cfgWe = 1'b0;
      driveOp(n);
      // next group mode is written alongside this operation
      // so the stream stays back-to-back across the change
      if (n + 1 < patCount && modeDiffers(n, n + 1)) begin
        writeConfigFor(n + 1);
      end
    end
    @(posedge clk);
    #(DriveSkew);
    inValid = 1'b0;
    cfgWe = 1'b0;
    sum = '0;
    // last result is due after the fixed latency
    // a few idle cycles more expose a missing or extra pulse
    repeat (Latency + 3) @(posedge clk);
    checkCount("output pulse count", issued, pulses);
    $display("No errors");
    $finish;
  end

endmodule

// ==== test/fmaPostPatterns.txt ====
// index fmt rm sign sumExp sumMant, then expected bits zero subnorm inexact
// all fields hex, fmt 1 single 0 half, rm 0 nearest-even 1 toward-zero
00 1 0 0 07F 0000001000000000000 3F800000 0 0 0
01 1 0 0 06A 1000002000000000000 41000001 0 0 0
02 1 0 0 076 0000000000040000080 32000001 0 0 0
03 1 0 1 07F 0000001800000000000 BFC00000 0 0 0
04 1 0 0 06A 1000001000000000001 41000001 0 0 1
05 1 0 0 06A 1000001000000000000 41000000 0 0 1
06 1 0 0 06A 1000003000000000000 41000002 0 0 1
07 1 0 0 06A 1FFFFFFFFFFFFFFFFFF 41800000 0 0 1
08 1 1 0 06A 1000001000000000001 41000000 0 0 1
09 1 1 0 06A 1000003000000000000 41000001 0 0 1
0A 1 1 0 3E8 1FFFFFFFFFFFFFFFFFF 007FFFFF 0 1 1
0B 1 0 0 3E8 1FFFFFFFFFFFFFFFFFF 00800000 0 0 1
0C 1 0 0 000 0000001000000000000 00400000 0 1 0
0D 1 0 1 07F 0000000000000000000 80000000 1 0 0
0E 0 0 0 07F 0000001000000000000 00003C00 0 0 0
0F 0 0 0 06A 1003000000000000000 00004801 0 0 1
10 0 0 0 06A 1006000000000000000 00004802 0 0 1
11 0 0 0 070 0000001000000000000 00000200 0 1 0
12 0 0 0 067 0000001800000000000 00000002 0 1 1
13 0 0 0 058 1FFFFFFFFFFFFFFFFFF 00000400 0 0 1
14 0 0 1 07F 0000000000000000000 00008000 1 0 0
15 0 1 0 06A 1003000000000000000 00004800 0 0 1
16 0 1 0 067 0000001800000000000 00000001 0 1 1
17 1 0 0 06A 1000003000000000000 41000002 0 0 1

// ==== compile.f ====
logic/fmaPostPkg.sv
logic/fmaModeRegs.sv
logic/sumLzc.sv
logic/fmaShiftCalc.sv
logic/normShifter.sv
logic/resultPacker.sv
logic/fmaPostTop.sv
test/fmaPostChk.sv
test/fmaPostTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the fma post-normalization testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module fmaPostTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/VfmaPostTb > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Errors found" "$log"; then
  echo "FAIL"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "FAIL: simulation exited with status $status"
  exit 1
fi
if ! grep -q "No errors" "$log"; then
  echo "FAIL: simulation ended without a result"
  exit 1
fi
echo "PASS"
exit 0
